//--- logic/llc_decode_settings.svh
// widths and line geometry for the llc input decode stage
// included by the package, by RTL that needs geometry, and by the testbench
`ifndef LLC_DECODE_SETTINGS_SVH
`define LLC_DECODE_SETTINGS_SVH

// line address split into tag and set
`define LINE_ADDR_BITS 16
`define SET_BITS 8
`define TAG_BITS (`LINE_ADDR_BITS - `SET_BITS)

// words in one cache line
`define WORDS_PER_LINE 4
`define WORD_OFF_BITS 2

// dma word count
`define DMA_LEN_BITS 12

`endif

//--- logic/llc_decode_pkg.sv
// types shared by the llc input decode stage and its testbench
// import by wildcard in the module or interface header
package llc_decode_pkg;

    `include "llc_decode_settings.svh"

    // line address, tag is the upper part and set the lower part
    typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [`TAG_BITS-1:0] tag_t;
    typedef logic [`SET_BITS-1:0] set_t;

    // word position inside a line
    typedef logic [`WORD_OFF_BITS-1:0] word_off_t;

    // number of words asked for by a dma request
    typedef logic [`DMA_LEN_BITS-1:0] dma_len_t;

    // kind of message held in the decode slot
    typedef enum logic [1:0] {
        slot_rsp,
        slot_req,
        slot_dma_new,
        slot_dma_next
    } slot_kind_e;

endpackage

//--- logic/decode_slot_if.sv
// decoded slot passed from source selection to address decode
// valid/ready handshake, the slot holds steady until it transfers
`timescale 1ns/10ps

interface decode_slot_if
    import llc_decode_pkg::*;
();

    logic valid;
    logic ready;
    slot_kind_e kind;
    // unused for continuation slots
    line_addr_t addr;

    modport sel (
        output valid,
        output kind,
        output addr,
        input ready
    );

    modport dec (
        input valid,
        input kind,
        input addr,
        output ready
    );

endinterface

//--- logic/dma_burst_if.sv
// burst control between address decode and the dma burst tracker
// the selection block only watches the pending flag
`timescale 1ns/10ps

interface dma_burst_if
    import llc_decode_pkg::*;
();

    logic start;
    logic advance;
    line_addr_t start_addr;
    word_off_t start_offset;
    dma_len_t start_length;
    logic start_read;
    logic pending;
    line_addr_t next_addr;

    modport dec (
        output start, advance, start_addr, start_offset, start_length, start_read,
        input next_addr
    );

    modport trk (
        input start, advance, start_addr, start_offset, start_length, start_read,
        output pending, next_addr
    );

    modport watch (
        input pending
    );

endinterface

//--- logic/llc_source_select.sv
// fixed priority pick of the next incoming message into the decode slot
// rsp first, then req, then burst continuation, then a new dma request
`timescale 1ns/10ps

module llc_source_select
    import llc_decode_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic rsp_valid,
    input logic req_valid,
    input logic dma_valid,
    input line_addr_t rsp_addr,
    input line_addr_t req_addr,
    output logic rsp_get,
    output logic req_get,
    output logic dma_get,
    output logic idle,
    decode_slot_if.sel slot,
    dma_burst_if.watch burst
);

    logic slot_valid;
    slot_kind_e slot_kind;
    line_addr_t slot_addr;

    logic dma_in_slot;
    logic take_next;
    logic take_new;
    logic load;
    logic pick;
    slot_kind_e pick_kind;

    // only one dma slot may be in flight at a time
    assign dma_in_slot = slot_valid &&
                         (slot_kind == slot_dma_new || slot_kind == slot_dma_next);

    assign take_next = burst.pending && !dma_in_slot;
    assign take_new = dma_valid && !burst.pending && !dma_in_slot;

    // slot can take a new item when empty or when it drains this cycle
    assign load = !slot_valid || slot.ready;

    always_comb begin
        pick = 1'b1;
        pick_kind = slot_rsp;
        if (rsp_valid) begin
            pick_kind = slot_rsp;
        end else if (req_valid) begin
            pick_kind = slot_req;
        end else if (take_next) begin
            pick_kind = slot_dma_next;
        end else if (take_new) begin
            pick_kind = slot_dma_new;
        end else begin
            pick = 1'b0;
        end
    end

    assign idle = !pick;

    assign rsp_get = load && rsp_valid;
    assign req_get = load && !rsp_valid && req_valid;

    // dma fields are read at issue, so the source is released only then
    assign dma_get = slot_valid && slot.ready && (slot_kind == slot_dma_new);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot_valid <= 1'b0;
            slot_kind <= slot_rsp;
        end else if (load) begin
            slot_valid <= pick;
            if (pick) begin
                slot_kind <= pick_kind;
            end
        end
    end

    // address kept for coherence messages only
    always_ff @(posedge clk) begin
        if (load && (rsp_valid || req_valid)) begin
            slot_addr <= rsp_valid ? rsp_addr : req_addr;
        end
    end

    assign slot.valid = slot_valid;
    assign slot.kind = slot_kind;
    assign slot.addr = slot_addr;

endmodule

//--- logic/llc_addr_decode.sv
// picks the line address of the slot, splits tag and set, checks the set table
// and issues to the memory stage; purely combinational
`timescale 1ns/10ps
`include "llc_decode_settings.svh"

module llc_addr_decode
    import llc_decode_pkg::*;
(
    input line_addr_t rsp_addr,
    input line_addr_t req_addr,
    input line_addr_t dma_addr,
    input word_off_t dma_offset,
    input dma_len_t dma_length,
    input logic dma_read,
    input logic set_in_table,
    input logic mem_ready,
    output logic check_set,
    output logic add_set,
    output logic mem_valid,
    output set_t lookup_set,
    output slot_kind_e mem_kind,
    output line_addr_t mem_addr,
    output tag_t mem_tag,
    decode_slot_if.dec slot,
    dma_burst_if.dec burst
);

    line_addr_t line_addr;
    logic issue;

    // address source depends on the message kind
    always_comb begin
        case (slot.kind)
            slot_rsp: line_addr = slot.addr;
            slot_req: line_addr = slot.addr;
            slot_dma_new: line_addr = dma_addr;
            default: line_addr = burst.next_addr;
        endcase
    end

    assign mem_tag = line_addr[`LINE_ADDR_BITS-1:`SET_BITS];
    assign lookup_set = line_addr[`SET_BITS-1:0];
    assign mem_addr = line_addr;
    assign mem_kind = slot.kind;

    assign check_set = slot.valid;

    // a busy set or a stalled memory stage holds the slot
    assign issue = slot.valid && !set_in_table && mem_ready;

    assign mem_valid = issue;
    assign add_set = issue;
    assign slot.ready = issue;

    assign burst.start = issue && (slot.kind == slot_dma_new);
    assign burst.advance = issue && (slot.kind == slot_dma_next);

    // burst fields straight from the held dma source
    assign burst.start_addr = dma_addr;
    assign burst.start_offset = dma_offset;
    assign burst.start_length = dma_length;
    assign burst.start_read = dma_read;

endmodule

//--- logic/llc_dma_tracker.sv
// state of a pending dma read burst: line address, words covered, length
// updated on the issue edge of a new dma slot or a continuation slot
`timescale 1ns/10ps
`include "llc_decode_settings.svh"

module llc_dma_tracker
    import llc_decode_pkg::*;
(
    input logic clk,
    input logic rst,
    dma_burst_if.trk burst
);

    line_addr_t burst_addr;
    dma_len_t covered;
    dma_len_t length;
    logic pending;

    dma_len_t first_words;
    dma_len_t covered_step;

    // the first line only covers the words from the start offset on
    assign first_words = dma_len_t'(`WORDS_PER_LINE) - dma_len_t'(burst.start_offset);
    assign covered_step = covered + dma_len_t'(`WORDS_PER_LINE);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pending <= 1'b0;
        end else if (burst.start) begin
            // writes never continue
            pending <= burst.start_read && (first_words < burst.start_length);
        end else if (burst.advance) begin
            pending <= covered_step < length;
        end
    end

    always_ff @(posedge clk) begin
        if (burst.start) begin
            burst_addr <= burst.start_addr;
            covered <= first_words;
            length <= burst.start_length;
        end else if (burst.advance) begin
            burst_addr <= burst_addr + 1'b1;
            covered <= covered_step;
        end
    end

    assign burst.pending = pending;

    // continuation always targets the line after the last one issued
    assign burst.next_addr = burst_addr + 1'b1;

endmodule

//--- logic/llc_decode_top.sv
// top of the llc input decode stage, wires selection, decode and burst tracker
// all outside signals are plain ports
`timescale 1ns/10ps

module llc_decode_top
    import llc_decode_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic rsp_valid,
    input logic req_valid,
    input logic dma_valid,
    input logic dma_read,
    input logic set_in_table,
    input logic mem_ready,
    input line_addr_t rsp_addr,
    input line_addr_t req_addr,
    input line_addr_t dma_addr,
    input word_off_t dma_offset,
    input dma_len_t dma_length,
    output logic rsp_get,
    output logic req_get,
    output logic dma_get,
    output logic idle,
    output logic check_set,
    output logic add_set,
    output logic mem_valid,
    output set_t lookup_set,
    output slot_kind_e mem_kind,
    output line_addr_t mem_addr,
    output tag_t mem_tag
);

    decode_slot_if slot_bus ();
    dma_burst_if burst_bus ();

    llc_source_select source_select_i (
        .clk(clk),
        .rst(rst),
        .rsp_valid(rsp_valid),
        .req_valid(req_valid),
        .dma_valid(dma_valid),
        .rsp_addr(rsp_addr),
        .req_addr(req_addr),
        .rsp_get(rsp_get),
        .req_get(req_get),
        .dma_get(dma_get),
        .idle(idle),
        .slot(slot_bus.sel),
        .burst(burst_bus.watch)
    );

    llc_addr_decode addr_decode_i (
        .rsp_addr(rsp_addr),
        .req_addr(req_addr),
        .dma_addr(dma_addr),
        .dma_offset(dma_offset),
        .dma_length(dma_length),
        .dma_read(dma_read),
        .set_in_table(set_in_table),
        .mem_ready(mem_ready),
        .check_set(check_set),
        .add_set(add_set),
        .mem_valid(mem_valid),
        .lookup_set(lookup_set),
        .mem_kind(mem_kind),
        .mem_addr(mem_addr),
        .mem_tag(mem_tag),
        .slot(slot_bus.dec),
        .burst(burst_bus.dec)
    );

    llc_dma_tracker dma_tracker_i (
        .clk(clk),
        .rst(rst),
        .burst(burst_bus.trk)
    );

endmodule

//--- test/llc_decode_tb.sv
// directed testbench for the llc input decode stage
// models the three sources, the set table and the memory stage around the dut
`timescale 1ns/10ps
`include "llc_decode_settings.svh"

module llc_decode_tb
    import llc_decode_pkg::*;
();

    localparam int clk_half = 20;
    localparam int test_cycle_budget = 400;
    localparam int timeout_cycles = 5 * test_cycle_budget;

    logic clk = 1'b0;
    logic rst;
    logic rsp_valid, req_valid, dma_valid, dma_read;
    logic set_in_table = 1'b0;
    logic mem_ready = 1'b1;
    line_addr_t rsp_addr, req_addr, dma_addr;
    word_off_t dma_offset;
    dma_len_t dma_length;
    logic rsp_get, req_get, dma_get, idle, set_check, add_set, mem_valid;
    set_t lookup_set;
    slot_kind_e mem_kind;
    line_addr_t mem_addr;
    tag_t mem_tag;

    // controls for the set table and memory models
    logic set_busy = 1'b0;
    logic mem_open = 1'b1;

    integer seed = 7493;
    int cycle_count = 0;
    int issue_count = 0;
    int rsp_gets = 0;
    int req_gets = 0;
    int dma_gets = 0;

    // every issue seen at the memory stage, in order
    slot_kind_e log_kind [256];
    line_addr_t log_addr [256];
    tag_t log_tag [256];
    set_t log_set [256];

    llc_decode_top llc_decode_top_i (.*, .check_set(set_check));

    always #clk_half clk = ~clk;

    always @(posedge clk) begin
        set_in_table <= set_busy;
        mem_ready <= mem_open;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_kind(input string name, input slot_kind_e exp, input slot_kind_e act);
        if (exp !== act) begin
            fail_run($sformatf("error: %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_addr(input string name, input line_addr_t exp, input line_addr_t act);
        if (exp !== act) begin
            fail_run($sformatf("error: %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (exp !== act) begin
            fail_run($sformatf("error: %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_set(input string name, input set_t exp, input set_t act);
        if (exp !== act) begin
            fail_run($sformatf("error: %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("error: %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            fail_run($sformatf("error: %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // issue log and get counters, sampled before the edge updates anything
    always @(posedge clk) begin
        if (rst === 1'b1) begin
            if (mem_valid) begin
                check_flag("add_set on issue", 1'b1, add_set);
                check_flag("check_set on issue", 1'b1, set_check);
                log_kind[issue_count] <= mem_kind;
                log_addr[issue_count] <= mem_addr;
                log_tag[issue_count] <= mem_tag;
                log_set[issue_count] <= lookup_set;
                issue_count <= issue_count + 1;
            end else begin
                check_flag("add_set without issue", 1'b0, add_set);
            end
            rsp_gets <= rsp_gets + int'(rsp_get);
            req_gets <= req_gets + int'(req_get);
            dma_gets <= dma_gets + int'(dma_get);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            fail_run($sformatf("timeout: tests did not finish in %0d cycles", timeout_cycles));
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_issues(input int target);
        while (issue_count < target) begin
            @(posedge clk);
        end
    endtask

    // coherence source, holds valid until its get pulse
    task automatic send_msg(input logic is_req, input line_addr_t a);
        @(posedge clk);
        if (is_req) begin
            req_valid <= 1'b1;
            req_addr <= a;
        end else begin
            rsp_valid <= 1'b1;
            rsp_addr <= a;
        end
        do begin
            @(posedge clk);
        end while (!(is_req ? req_get : rsp_get));
        if (is_req) begin
            req_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
        end
    endtask

    task automatic send_dma(input line_addr_t a, input word_off_t off, input dma_len_t len,
                            input logic rd);
        @(posedge clk);
        dma_valid <= 1'b1;
        dma_addr <= a;
        dma_offset <= off;
        dma_length <= len;
        dma_read <= rd;
        do begin
            @(posedge clk);
        end while (!dma_get);
        dma_valid <= 1'b0;
    endtask

    // tag is the upper part of the line address, set the lower part
    task automatic expect_issue(input string name, input int idx, input slot_kind_e kind,
                                input line_addr_t a);
        check_kind(name, kind, log_kind[idx]);
        check_addr(name, a, log_addr[idx]);
        check_tag(name, a[`LINE_ADDR_BITS-1:`SET_BITS], log_tag[idx]);
        check_set(name, a[`SET_BITS-1:0], log_set[idx]);
    endtask

    task automatic run_single_rsp();
        line_addr_t a;
        int base;
        int rb;
        a = line_addr_t'($random(seed));
        base = issue_count;
        rb = rsp_gets;
        send_msg(1'b0, a);
        wait_issues(base + 1);
        wait_cycles(2);
        check_count("single rsp issues", base + 1, issue_count);
        check_count("single rsp gets", 1, rsp_gets - rb);
        expect_issue("single rsp", base, slot_rsp, a);
    endtask

    task automatic run_priority();
        line_addr_t a;
        line_addr_t b;
        int base;
        int rb;
        int qb;
        a = line_addr_t'($random(seed));
        b = line_addr_t'($random(seed));
        base = issue_count;
        rb = rsp_gets;
        qb = req_gets;
        fork
            send_msg(1'b0, a);
            send_msg(1'b1, b);
        join
        wait_issues(base + 2);
        check_flag("priority idle", 1'b1, idle);
        expect_issue("priority first", base, slot_rsp, a);
        expect_issue("priority second", base + 1, slot_req, b);
        check_count("priority rsp gets", 1, rsp_gets - rb);
        check_count("priority req gets", 1, req_gets - qb);
    endtask

    // busy set or stalled memory stage, then release
    task automatic run_hold(input string name, input logic hold_mem);
        line_addr_t a;
        line_addr_t b;
        int base;
        int gb;
        a = line_addr_t'($random(seed));
        b = line_addr_t'($random(seed));
        base = issue_count;
        gb = rsp_gets + req_gets;
        @(posedge clk);
        if (hold_mem) begin
            mem_open <= 1'b0;
        end else begin
            set_busy <= 1'b1;
        end
        wait_cycles(2);
        fork
            begin
                send_msg(1'b0, a);
                send_msg(1'b1, b);
            end
            begin
                wait_cycles(12);
                check_count({name, " issues while held"}, base, issue_count);
                check_count({name, " gets while held"}, 1, rsp_gets + req_gets - gb);
                check_set({name, " held lookup"}, a[`SET_BITS-1:0], lookup_set);
                mem_open <= 1'b1;
                set_busy <= 1'b0;
            end
        join
        wait_issues(base + 2);
        expect_issue({name, " held rsp"}, base, slot_rsp, a);
        expect_issue({name, " queued req"}, base + 1, slot_req, b);
    endtask

    task automatic run_dma_burst();
        line_addr_t a;
        line_addr_t b;
        line_addr_t c;
        int base;
        int db;
        a = line_addr_t'($random(seed));
        b = line_addr_t'($random(seed));
        c = line_addr_t'($random(seed));
        base = issue_count;
        db = dma_gets;
        fork
            begin
                send_dma(a, 2'd1, 12'd10, 1'b1);
                send_dma(b, 2'd0, 12'd4, 1'b1);
            end
            begin
                // a request that shows up while the burst runs
                do begin
                    @(posedge clk);
                end while (!dma_get);
                send_msg(1'b1, c);
            end
        join
        wait_issues(base + 5);
        wait_cycles(8);
        check_count("dma burst issues", base + 5, issue_count);
        expect_issue("dma burst first", base, slot_dma_new, a);
        expect_issue("dma burst next 1", base + 1, slot_dma_next, line_addr_t'(a + 1));
        expect_issue("dma burst request", base + 2, slot_req, c);
        expect_issue("dma burst next 2", base + 3, slot_dma_next, line_addr_t'(a + 2));
        expect_issue("dma burst second dma", base + 4, slot_dma_new, b);
        check_count("dma burst gets", 2, dma_gets - db);
    endtask

    task automatic run_dma_write();
        line_addr_t a;
        line_addr_t b;
        int base;
        int db;
        a = line_addr_t'($random(seed));
        b = line_addr_t'($random(seed));
        base = issue_count;
        db = dma_gets;
        send_dma(a, 2'd2, dma_len_t'($random(seed)), 1'b0);
        send_dma(b, 2'd0, 12'd3, 1'b1);
        wait_issues(base + 2);
        wait_cycles(8);
        check_count("dma write issues", base + 2, issue_count);
        expect_issue("dma write line", base, slot_dma_new, a);
        expect_issue("dma after write", base + 1, slot_dma_new, b);
        check_count("dma write gets", 2, dma_gets - db);
    endtask

    initial begin
        rst <= 1'b0;
        rsp_valid <= 1'b0;
        req_valid <= 1'b0;
        dma_valid <= 1'b0;
        dma_read <= 1'b0;
        rsp_addr <= '0;
        req_addr <= '0;
        dma_addr <= '0;
        dma_offset <= '0;
        dma_length <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        check_flag("reset mem_valid", 1'b0, mem_valid);
        check_flag("reset check_set", 1'b0, set_check);
        check_flag("reset idle", 1'b1, idle);
        run_single_rsp();
        run_priority();
        run_hold("set hold", 1'b0);
        run_hold("mem hold", 1'b1);
        run_dma_burst();
        run_dma_write();
        wait_cycles(2);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- llc_decode_top.f
+incdir+logic
logic/llc_decode_pkg.sv
logic/decode_slot_if.sv
logic/dma_burst_if.sv
logic/llc_source_select.sv
logic/llc_addr_decode.sv
logic/llc_dma_tracker.sv
logic/llc_decode_top.sv
test/llc_decode_tb.sv

//--- Bender.yml
package:
  name: llc_decode

sources:
  - include_dirs:
      - logic
    files:
      - logic/llc_decode_pkg.sv
      - logic/decode_slot_if.sv
      - logic/dma_burst_if.sv
      - logic/llc_source_select.sv
      - logic/llc_addr_decode.sv
      - logic/llc_dma_tracker.sv
      - logic/llc_decode_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/llc_decode_tb.sv
